/* Makefile */
# Verilator build and run for the MMIO subsystem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module mmio_tb -o mmio_sim

# The run passes only if the pass line shows up in the output
run: build
	out="$$(./obj_dir/mmio_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST PASSED$$'

lint:
	verilator --lint-only --timing -f build.f --top-module mmio_tb
	verilator --lint-only +incdir+hdl hdl/mmio_pkg.sv hdl/mmio_addr_decoder.sv \
		hdl/mmio_keypad_register.sv hdl/mmio_wb_manager.sv hdl/mmio_sram_wb.sv \
		hdl/mmio_access_control.sv hdl/mmio_top.sv --top-module mmio_top

clean:
	rm -rf obj_dir

/* build.f */
+incdir+hdl
hdl/mmio_pkg.sv
hdl/mmio_addr_decoder.sv
hdl/mmio_keypad_register.sv
hdl/mmio_wb_manager.sv
hdl/mmio_sram_wb.sv
hdl/mmio_access_control.sv
hdl/mmio_top.sv
tests/mmio_tb.sv

/* hdl/mmio_access_control.sv */
`timescale 1ns/1ps
`include "mmio_settings.svh"

module mmio_access_control (
    input  logic                clk,
    input  logic                reset,
    input  mmio_pkg::cpu_req_t  cpu_req_i,
    input  mmio_pkg::region_e   region_i,
    input  logic [31:0]         key_data_i,
    output logic                key_rd_o,
    output logic                wbm_start_o,
    output logic                wbm_we_o,
    input  logic                wbm_done_i,
    input  logic [31:0]         wbm_rdata_i,
    output mmio_pkg::disp_out_t disp_o,
    input  logic                disp_ack_i,
    output mmio_pkg::cpu_rsp_t  cpu_rsp_o
);

    logic                busy_q;
    mmio_pkg::req_kind_e kind_q;
    mmio_pkg::region_e   region_q;
    logic                imm_ack_q;
    logic                wen_q;
    logic                disp_done_q;
    logic [31:0]         local_data_q;
    logic [31:0]         disp_addr_q;
    logic [31:0]         disp_data_q;
    logic                start;
    logic                is_load;
    logic                to_ram;
    logic                disp_start;
    logic                ack_any;

    assign start      = !busy_q && (cpu_req_i.kind != mmio_pkg::REQ_NONE);
    assign is_load    = (cpu_req_i.kind == mmio_pkg::REQ_LOAD);
    assign to_ram     = (region_i == mmio_pkg::RGN_RAM);
    assign disp_start = start && (region_i == mmio_pkg::RGN_DISP)
                        && (cpu_req_i.kind == mmio_pkg::REQ_STORE);

    // Kick off the target in the request cycle
    assign wbm_start_o = start && to_ram;
    assign wbm_we_o    = (cpu_req_i.kind == mmio_pkg::REQ_STORE);
    assign key_rd_o    = start && (region_i == mmio_pkg::RGN_KEY) && is_load;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy_q      <= 1'b0;
            kind_q      <= mmio_pkg::REQ_NONE;
            region_q    <= mmio_pkg::RGN_NONE;
            imm_ack_q   <= 1'b0;
            wen_q       <= 1'b0;
            disp_done_q <= 1'b0;
        end else begin
            if (start) begin
                busy_q   <= 1'b1;
                kind_q   <= cpu_req_i.kind;
                region_q <= region_i;
            end else if (ack_any) begin
                busy_q <= 1'b0;
            end
            // Everything but RAM and display stores completes next cycle
            imm_ack_q <= start && !to_ram && !disp_start;
            // Display write waits on the external acknowledge
            if (disp_start) begin
                wen_q <= 1'b1;
            end else if (wen_q && disp_ack_i) begin
                wen_q <= 1'b0;
            end
            disp_done_q <= wen_q && disp_ack_i;
        end
    end

    // Load word for non-RAM targets, keypad sampled as of the request cycle
    always_ff @(posedge clk) begin
        if (start) begin
            if ((region_i == mmio_pkg::RGN_KEY) && is_load) begin
                local_data_q <= key_data_i;
            end else begin
                local_data_q <= `MMIO_BAD_DATA;
            end
        end
        if (disp_start) begin
            disp_addr_q <= cpu_req_i.addr;
            disp_data_q <= cpu_req_i.wdata;
        end
    end

    assign ack_any = busy_q && (imm_ack_q || disp_done_q || wbm_done_i);

    assign disp_o.wen  = wen_q;
    assign disp_o.addr = disp_addr_q;
    assign disp_o.data = disp_data_q;

    assign cpu_rsp_o.i_ack = ack_any && (kind_q == mmio_pkg::REQ_FETCH);
    assign cpu_rsp_o.d_ack = ack_any && (kind_q != mmio_pkg::REQ_FETCH);
    assign cpu_rsp_o.rdata = (region_q == mmio_pkg::RGN_RAM) ? wbm_rdata_i : local_data_q;

    a_one_ack: assert property (
        @(posedge clk) disable iff (reset)
        !(cpu_rsp_o.d_ack && cpu_rsp_o.i_ack)
    ) else $error("d_ack and i_ack together");

    // Manager only finishes cycles this block started
    a_done_owned: assert property (
        @(posedge clk) disable iff (reset)
        wbm_done_i |-> busy_q && (region_q == mmio_pkg::RGN_RAM)
    ) else $error("manager done without a RAM access");

endmodule

/* hdl/mmio_addr_decoder.sv */
`timescale 1ns/1ps
`include "mmio_settings.svh"

module mmio_addr_decoder (
    input  logic [31:0]       addr_i,
    output mmio_pkg::region_e region_o
);

    logic in_ram;
    logic in_key;
    logic in_disp;

    assign in_ram  = (addr_i < `MMIO_RAM_LIMIT);
    assign in_key  = (addr_i == `MMIO_KEY_ADDR);
    assign in_disp = (addr_i >= `MMIO_DISP_BASE) && (addr_i < `MMIO_DISP_LIMIT);

    // RAM wins if the map were ever to overlap
    always_comb begin
        if (in_ram) begin
            region_o = mmio_pkg::RGN_RAM;
        end else if (in_key) begin
            region_o = mmio_pkg::RGN_KEY;
        end else if (in_disp) begin
            region_o = mmio_pkg::RGN_DISP;
        end else begin
            region_o = mmio_pkg::RGN_NONE;
        end
    end

    // A known address always names a known region
    always_comb begin
        if (!$isunknown(addr_i)) begin
            a_region_known: assert (!$isunknown(region_o))
                else $error("decoder produced unknown region");
        end
    end

endmodule

/* hdl/mmio_keypad_register.sv */
`timescale 1ns/1ps

module mmio_keypad_register (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  key_code_i,
    input  logic [1:0]  key_app_i,
    input  logic        key_rise_i,
    input  logic        rd_i,
    output logic [31:0] key_data_o
);

    logic       valid_q;
    logic [4:0] code_q;
    logic [1:0] app_q;

    // Latest key event
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            code_q <= '0;
            app_q  <= '0;
        end else if (key_rise_i) begin
            code_q <= key_code_i;
            app_q  <= key_app_i;
        end
    end

    // A new rise beats a read in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (key_rise_i) begin
            valid_q <= 1'b1;
        end else if (rd_i) begin
            valid_q <= 1'b0;
        end
    end

    // valid | zeros | app | code
    always_comb begin
        key_data_o      = '0;
        key_data_o[31]  = valid_q;
        key_data_o[6:5] = app_q;
        key_data_o[4:0] = code_q;
    end

endmodule

/* hdl/mmio_pkg.sv */
package mmio_pkg;

    typedef enum logic [1:0] {
        REQ_NONE,
        REQ_FETCH,
        REQ_LOAD,
        REQ_STORE
    } req_kind_e;

    typedef enum logic [1:0] {
        RGN_RAM,
        RGN_KEY,
        RGN_DISP,
        RGN_NONE
    } region_e;

    typedef enum logic [1:0] {
        WBM_IDLE,
        WBM_BUS,
        WBM_DONE
    } wbm_state_e;

    // CPU side, held until acknowledged
    typedef struct packed {
        req_kind_e   kind;
        logic [31:0] addr;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic        d_ack;
        logic        i_ack;
        logic [31:0] rdata;
    } cpu_rsp_t;

    // Wishbone classic, manager to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_m2s_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_s2m_t;

    typedef struct packed {
        logic        wen;
        logic [31:0] addr;
        logic [31:0] data;
    } disp_out_t;

endpackage

/* hdl/mmio_settings.svh */
`ifndef MMIO_SETTINGS_SVH
`define MMIO_SETTINGS_SVH

// SRAM depth in 32-bit words, word 0 at byte address 0
`define MMIO_RAM_WORDS 1024

// First byte address above RAM
`define MMIO_RAM_LIMIT 32'h0000_1000

// Keypad data word
`define MMIO_KEY_ADDR 32'hF000_0000

// Display window, limit is exclusive
`define MMIO_DISP_BASE 32'hF000_1000
`define MMIO_DISP_LIMIT 32'hF000_2000

// Returned by loads that have no real source
`define MMIO_BAD_DATA 32'hDEAD_BEEF

`endif

/* hdl/mmio_sram_wb.sv */
`timescale 1ns/1ps
`include "mmio_settings.svh"

module mmio_sram_wb (
    input  logic              clk,
    input  logic              reset,
    input  mmio_pkg::wb_m2s_t wb_i,
    output mmio_pkg::wb_s2m_t wb_o
);

    localparam int AW = $clog2(`MMIO_RAM_WORDS);

    logic [31:0]   mem [0:`MMIO_RAM_WORDS-1];
    logic [AW-1:0] word_idx;
    logic [31:0]   rdata_q;
    logic          ack_q;
    logic          strobe;

    // Byte address to word index
    assign word_idx = wb_i.adr[AW+1:2];

    // Only answer once per strobe
    assign strobe = wb_i.cyc && wb_i.stb && !ack_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            if (wb_i.we) begin
                mem[word_idx] <= wb_i.dat;
            end
            rdata_q <= mem[word_idx];
        end
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = rdata_q;

    // Full-word accesses only
    a_sel_full: assert property (
        @(posedge clk) disable iff (reset)
        wb_i.stb |-> wb_i.sel == 4'hF
    ) else $error("partial byte select");

    // Decoder keeps other regions off the bus
    a_adr_in_ram: assert property (
        @(posedge clk) disable iff (reset)
        wb_i.stb |-> wb_i.adr < `MMIO_RAM_LIMIT
    ) else $error("bus address outside RAM");

endmodule

/* hdl/mmio_top.sv */
`timescale 1ns/1ps

module mmio_top (
    input  logic                clk,
    input  logic                reset,
    input  mmio_pkg::cpu_req_t  cpu_req_i,
    output mmio_pkg::cpu_rsp_t  cpu_rsp_o,
    input  logic [4:0]          key_code_i,
    input  logic [1:0]          key_app_i,
    input  logic                key_rise_i,
    output mmio_pkg::disp_out_t disp_o,
    input  logic                disp_ack_i
);

    mmio_pkg::region_e region;
    logic [31:0]       key_data;
    logic              key_rd;
    logic              wbm_start;
    logic              wbm_we;
    logic              wbm_done;
    logic [31:0]       wbm_rdata;
    mmio_pkg::wb_m2s_t wb_m2s;
    mmio_pkg::wb_s2m_t wb_s2m;

    mmio_addr_decoder u_addr_decoder (
        .addr_i   (cpu_req_i.addr),
        .region_o (region)
    );

    mmio_keypad_register u_keypad_register (
        .clk        (clk),
        .reset      (reset),
        .key_code_i (key_code_i),
        .key_app_i  (key_app_i),
        .key_rise_i (key_rise_i),
        .rd_i       (key_rd),
        .key_data_o (key_data)
    );

    // Address and store data go straight from the CPU request
    mmio_wb_manager u_wb_manager (
        .clk     (clk),
        .reset   (reset),
        .start_i (wbm_start),
        .we_i    (wbm_we),
        .adr_i   (cpu_req_i.addr),
        .dat_i   (cpu_req_i.wdata),
        .wb_o    (wb_m2s),
        .wb_i    (wb_s2m),
        .done_o  (wbm_done),
        .rdata_o (wbm_rdata)
    );

    mmio_sram_wb u_sram_wb (
        .clk   (clk),
        .reset (reset),
        .wb_i  (wb_m2s),
        .wb_o  (wb_s2m)
    );

    mmio_access_control u_access_control (
        .clk         (clk),
        .reset       (reset),
        .cpu_req_i   (cpu_req_i),
        .region_i    (region),
        .key_data_i  (key_data),
        .key_rd_o    (key_rd),
        .wbm_start_o (wbm_start),
        .wbm_we_o    (wbm_we),
        .wbm_done_i  (wbm_done),
        .wbm_rdata_i (wbm_rdata),
        .disp_o      (disp_o),
        .disp_ack_i  (disp_ack_i),
        .cpu_rsp_o   (cpu_rsp_o)
    );

endmodule

/* hdl/mmio_wb_manager.sv */
`timescale 1ns/1ps

module mmio_wb_manager (
    input  logic              clk,
    input  logic              reset,
    input  logic              start_i,
    input  logic              we_i,
    input  logic [31:0]       adr_i,
    input  logic [31:0]       dat_i,
    output mmio_pkg::wb_m2s_t wb_o,
    input  mmio_pkg::wb_s2m_t wb_i,
    output logic              done_o,
    output logic [31:0]       rdata_o
);

    mmio_pkg::wbm_state_e state_q;
    mmio_pkg::wbm_state_e state_d;

    logic        we_q;
    logic [31:0] adr_q;
    logic [31:0] dat_q;
    logic [31:0] rdata_q;
    logic        accept;
    logic        bus_end;

    assign accept  = (state_q == mmio_pkg::WBM_IDLE) && start_i;
    assign bus_end = (state_q == mmio_pkg::WBM_BUS) && wb_i.ack;

    always_comb begin
        state_d = state_q;
        case (state_q)
            mmio_pkg::WBM_IDLE: begin
                if (start_i) begin
                    state_d = mmio_pkg::WBM_BUS;
                end
            end
            mmio_pkg::WBM_BUS: begin
                if (wb_i.ack) begin
                    state_d = mmio_pkg::WBM_DONE;
                end
            end
            mmio_pkg::WBM_DONE: begin
                state_d = mmio_pkg::WBM_IDLE;
            end
            default: begin
                state_d = mmio_pkg::WBM_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= mmio_pkg::WBM_IDLE;
            we_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                we_q <= we_i;
            end else if (bus_end) begin
                we_q <= 1'b0;
            end
        end
    end

    // Address and write data held for the whole cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            adr_q <= adr_i;
            dat_q <= dat_i;
        end
        if (bus_end) begin
            rdata_q <= wb_i.dat;
        end
    end

    assign wb_o.cyc = (state_q == mmio_pkg::WBM_BUS);
    assign wb_o.stb = (state_q == mmio_pkg::WBM_BUS);
    assign wb_o.we  = we_q;
    assign wb_o.sel = 4'hF;
    assign wb_o.adr = adr_q;
    assign wb_o.dat = dat_q;

    assign done_o  = (state_q == mmio_pkg::WBM_DONE);
    assign rdata_o = rdata_q;

    a_stb_cyc: assert property (
        @(posedge clk) disable iff (reset)
        wb_o.stb |-> wb_o.cyc
    ) else $error("stb without cyc");

    a_adr_stable: assert property (
        @(posedge clk) disable iff (reset)
        wb_o.stb && !wb_i.ack |=> $stable(wb_o.adr)
    ) else $error("address moved during strobe");

    // Access control must not start a second cycle while one is in flight
    a_start_idle: assert property (
        @(posedge clk) disable iff (reset)
        start_i |-> state_q == mmio_pkg::WBM_IDLE
    ) else $error("start while manager busy");

endmodule

/* tests/mmio_tb.sv */
`timescale 1ns/1ps
`include "mmio_settings.svh"

module mmio_tb;

    localparam int ACK_TIMEOUT = 64;
    localparam int RAM_PAIRS   = 24;

    logic                clk;
    logic                reset;
    mmio_pkg::cpu_req_t  cpu_req;
    mmio_pkg::cpu_rsp_t  cpu_rsp;
    logic [4:0]          key_code;
    logic [1:0]          key_app;
    logic                key_rise;
    mmio_pkg::disp_out_t disp;
    logic                disp_ack;

    // Expected response of the access in flight, mask of zero skips the data
    logic        exp_fetch;
    int          exp_latency;
    logic [31:0] exp_data;
    logic [31:0] exp_mask;
    logic [31:0] exp_disp_addr;
    logic [31:0] exp_disp_data;
    int          age;
    int          resp_delay;
    logic        resp_armed;
    logic [31:0] ref_mem [0:`MMIO_RAM_WORDS-1];
    int          ram_words [$];

    mmio_top mmio_top_i (
        .clk        (clk),
        .reset      (reset),
        .cpu_req_i  (cpu_req),
        .cpu_rsp_o  (cpu_rsp),
        .key_code_i (key_code),
        .key_app_i  (key_app),
        .key_rise_i (key_rise),
        .disp_o     (disp),
        .disp_ack_i (disp_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    // Cycles since the current request was first presented
    always @(posedge clk) begin
        if (reset || cpu_req.kind == mmio_pkg::REQ_NONE) begin
            age <= 0;
        end else begin
            age <= age + 1;
        end
    end

    // Display side answers after 0 to 5 cycles
    initial begin
        disp_ack   = 1'b0;
        resp_armed = 1'b0;
        resp_delay = 0;
        forever begin
            @(negedge clk);
            if (disp_ack) begin
                disp_ack = 1'b0;
            end else if (disp.wen) begin
                if (!resp_armed) begin
                    resp_delay = $urandom_range(5, 0);
                    resp_armed = 1'b1;
                end
                if (resp_delay == 0) begin
                    disp_ack   = 1'b1;
                    resp_armed = 1'b0;
                end else begin
                    resp_delay = resp_delay - 1;
                end
            end
        end
    end

    a_quiet_when_idle: assert property (
        @(posedge clk) disable iff (reset)
        cpu_req.kind == mmio_pkg::REQ_NONE && $past(cpu_req.kind) == mmio_pkg::REQ_NONE
        |-> !cpu_rsp.d_ack && !cpu_rsp.i_ack && !disp.wen
    ) else report_failure($sformatf("error %0t: ack or wen high with no request", $time));

    a_ack_kind: assert property (
        @(posedge clk) disable iff (reset)
        cpu_rsp.d_ack || cpu_rsp.i_ack |-> cpu_rsp.i_ack == exp_fetch && cpu_rsp.d_ack != exp_fetch
    ) else report_failure($sformatf("error %0t: wrong ack, d_ack %b i_ack %b",
                                    $time, cpu_rsp.d_ack, cpu_rsp.i_ack));

    a_ack_latency: assert property (
        @(posedge clk) disable iff (reset)
        (cpu_rsp.d_ack || cpu_rsp.i_ack) && exp_latency != 0 |-> age == exp_latency
    ) else report_failure($sformatf("error %0t: ack after %0d cycles, expected %0d",
                                    $time, age, exp_latency));

    a_ack_data: assert property (
        @(posedge clk) disable iff (reset)
        cpu_rsp.d_ack || cpu_rsp.i_ack |-> ((cpu_rsp.rdata ^ exp_data) & exp_mask) == 32'h0
    ) else report_failure($sformatf("error %0t: rdata %h, expected %h under mask %h",
                                    $time, cpu_rsp.rdata, exp_data, exp_mask));

    a_disp_fields: assert property (
        @(posedge clk) disable iff (reset)
        disp.wen |-> disp.addr == exp_disp_addr && disp.data == exp_disp_data
    ) else report_failure($sformatf("error %0t: display write %h/%h, expected %h/%h",
                                    $time, disp.addr, disp.data, exp_disp_addr, exp_disp_data));

    a_wen_held: assert property (
        @(posedge clk) disable iff (reset)
        disp.wen && !disp_ack |=> disp.wen
    ) else report_failure($sformatf("error %0t: wen dropped before display ack", $time));

    a_disp_done: assert property (
        @(posedge clk) disable iff (reset)
        disp.wen && disp_ack |=> !disp.wen && cpu_rsp.d_ack
    ) else report_failure($sformatf("error %0t: no d_ack one cycle after display ack", $time));

    // Display stores end only on the external acknowledge
    a_disp_end: assert property (
        @(posedge clk) disable iff (reset)
        (cpu_rsp.d_ack || cpu_rsp.i_ack) && exp_latency == 0 |-> $past(disp_ack)
    ) else report_failure($sformatf("error %0t: display store acked early", $time));

    task automatic run_access(input mmio_pkg::req_kind_e kind, input logic [31:0] addr,
                              input logic [31:0] wdata, input int latency,
                              input logic [31:0] data, input logic [31:0] mask);
        int   waited;
        logic seen;
        @(negedge clk);
        exp_fetch     = (kind == mmio_pkg::REQ_FETCH);
        exp_latency   = latency;
        exp_data      = data;
        exp_mask      = mask;
        cpu_req.kind  = kind;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        waited        = 0;
        seen          = 1'b0;
        while (!seen && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited = waited + 1;
            seen   = cpu_rsp.d_ack || cpu_rsp.i_ack;
        end
        if (!seen) begin
            report_failure($sformatf("timeout: access to %h was never acknowledged", addr));
        end
        cpu_req.kind = mmio_pkg::REQ_NONE;
    endtask

    task automatic ram_store(input int word, input logic [31:0] data);
        ref_mem[word] = data;
        run_access(mmio_pkg::REQ_STORE, word << 2, data, 3, 32'h0, 32'h0);
    endtask

    task automatic ram_load(input int word);
        run_access(mmio_pkg::REQ_LOAD, word << 2, 32'h0, 3, ref_mem[word], 32'hFFFF_FFFF);
    endtask

    task automatic press_key(input logic [4:0] code, input logic [1:0] app);
        @(negedge clk);
        key_code = code;
        key_app  = app;
        key_rise = 1'b1;
        @(negedge clk);
        key_rise = 1'b0;
    endtask

    initial begin
        int          word;
        logic [31:0] rnd;
        logic [31:0] key_word;
        logic [31:0] addr;
        void'($urandom(32'h9d3f_f088));
        reset         = 1'b1;
        cpu_req.kind  = mmio_pkg::REQ_NONE;
        cpu_req.addr  = 32'h0;
        cpu_req.wdata = 32'h0;
        key_code      = 5'h0;
        key_app       = 2'h0;
        key_rise      = 1'b0;
        exp_fetch     = 1'b0;
        exp_latency   = 1;
        exp_data      = 32'h0;
        exp_mask      = 32'h0;
        exp_disp_addr = 32'h0;
        exp_disp_data = 32'h0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (!cpu_rsp.d_ack && !cpu_rsp.i_ack && !disp.wen)
            else report_failure($sformatf("error %0t: outputs not low after reset", $time));
        repeat (4) @(negedge clk);

        // RAM stores, then loads from the same words
        for (int i = 0; i < RAM_PAIRS; i++) begin
            word = $urandom_range(`MMIO_RAM_WORDS - 1, 0);
            ram_words.push_back(word);
            ram_store(word, $urandom);
        end
        foreach (ram_words[i]) begin
            ram_load(ram_words[i]);
        end

        // Fetches inside and outside RAM
        word = ram_words[0];
        run_access(mmio_pkg::REQ_FETCH, word << 2, 32'h0, 3, ref_mem[word], 32'hFFFF_FFFF);
        rnd = $urandom;
        addr = 32'h8000_0000 | (rnd & 32'h0FFF_FFFC);
        run_access(mmio_pkg::REQ_FETCH, addr, 32'h0, 1, `MMIO_BAD_DATA, 32'hFFFF_FFFF);
        run_access(mmio_pkg::REQ_FETCH, `MMIO_KEY_ADDR, 32'h0, 1, `MMIO_BAD_DATA, 32'hFFFF_FFFF);

        // Key events, each read twice
        repeat (4) begin
            rnd = $urandom;
            press_key(rnd[4:0], rnd[6:5]);
            key_word      = 32'h0;
            key_word[31]  = 1'b1;
            key_word[6:5] = rnd[6:5];
            key_word[4:0] = rnd[4:0];
            run_access(mmio_pkg::REQ_LOAD, `MMIO_KEY_ADDR, 32'h0, 1, key_word, 32'hFFFF_FFFF);
            run_access(mmio_pkg::REQ_LOAD, `MMIO_KEY_ADDR, 32'h0, 1, 32'h0, 32'h8000_0000);
        end
        run_access(mmio_pkg::REQ_STORE, `MMIO_KEY_ADDR, $urandom, 1, 32'h0, 32'h0);

        // Display stores with random responder delay
        repeat (6) begin
            rnd = $urandom;
            exp_disp_addr = `MMIO_DISP_BASE | {20'h0, rnd[9:0], 2'b00};
            exp_disp_data = $urandom;
            run_access(mmio_pkg::REQ_STORE, exp_disp_addr, exp_disp_data, 0, 32'h0, 32'h0);
        end

        // Error word for display loads and unmapped loads
        rnd = $urandom;
        addr = `MMIO_DISP_BASE | {20'h0, rnd[9:0], 2'b00};
        run_access(mmio_pkg::REQ_LOAD, addr, 32'h0, 1, `MMIO_BAD_DATA, 32'hFFFF_FFFF);
        addr = 32'h8000_0000 | (rnd & 32'h0FFF_FFFC);
        run_access(mmio_pkg::REQ_LOAD, addr, 32'h0, 1, `MMIO_BAD_DATA, 32'hFFFF_FFFF);

        // Stores just above RAM would alias these words if they leaked through
        for (int i = 0; i < 3; i++) begin
            word = ram_words[i];
            addr = `MMIO_RAM_LIMIT | (word << 2);
            run_access(mmio_pkg::REQ_LOAD, addr, 32'h0, 1, `MMIO_BAD_DATA, 32'hFFFF_FFFF);
            run_access(mmio_pkg::REQ_STORE, addr, ~ref_mem[word], 1, 32'h0, 32'h0);
            ram_load(word);
        end

        repeat (4) @(negedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule
